//--- rtl/rv_pkg.sv
package rv_pkg;

    // machine widths
    localparam int XLEN        = 32;
    localparam int RF_ADDR_W   = 5;
    localparam int DMEM_DEPTH  = 256;
    localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    localparam rf_addr_t RF_X0_ZERO = 5'd0;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_A_SEL_RS1,
        ALU_A_SEL_ZERO,
        ALU_A_SEL_FWD
    } alu_a_sel_t;

    typedef enum logic [1:0] {
        ALU_B_SEL_RS2,
        ALU_B_SEL_IMM,
        ALU_B_SEL_FWD
    } alu_b_sel_t;

    // source of forwarded data
    typedef enum logic {
        FWD_BE_EWBK,
        FWD_BE_WBK
    } fwd_be_t;

    typedef struct packed {
        logic to_dec;
        logic to_exe;
    } hazard_be_t;

    typedef struct packed {
        logic            valid;
        rf_addr_t        rs1;
        rf_addr_t        rs2;
        rf_addr_t        rd;
        logic            rd_we;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        alu_op_t         alu_op;
        alu_a_sel_t      alu_a_sel;
        alu_b_sel_t      alu_b_sel;
        logic            load;
        logic            store;
    } dec_exe_t;

    typedef struct packed {
        logic            valid;
        rf_addr_t        rd;
        logic            rd_we;
        logic [XLEN-1:0] alu_res;
        logic [XLEN-1:0] store_data;
        logic            load;
        logic            store;
    } exe_mem_t;

    typedef struct packed {
        logic            valid;
        rf_addr_t        rd;
        logic            rd_we;
        logic [XLEN-1:0] alu_res;
        logic            load;
    } mem_wbk_t;

    typedef struct packed {
        logic            valid;
        rf_addr_t        rd;
        logic [XLEN-1:0] data;
    } wb_t;

endpackage

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_pkg::rf_addr_t        ra1,
    input  rv_pkg::rf_addr_t        ra2,
    input  rv_pkg::wb_t             wb,
    output logic [rv_pkg::XLEN-1:0] rd1,
    output logic [rv_pkg::XLEN-1:0] rd2
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != rv_pkg::RF_X0_ZERO)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // no same-cycle bypass here, writeback forwarding covers it
    assign rd1 = (ra1 == rv_pkg::RF_X0_ZERO) ? '0 : regs[ra1];
    assign rd2 = (ra2 == rv_pkg::RF_X0_ZERO) ? '0 : regs[ra2];

endmodule

//--- rtl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [rv_pkg::XLEN-1:0] inst,
    input  logic                    inst_valid,
    input  logic                    stall_dec,
    input  logic                    bubble_exe,
    input  logic [rv_pkg::XLEN-1:0] rf_rd1,
    input  logic [rv_pkg::XLEN-1:0] rf_rd2,
    input  logic                    rf_a_sel_fwd,
    input  logic                    rf_b_sel_fwd,
    input  rv_pkg::fwd_be_t         fwd_be_rs1_dec,
    input  rv_pkg::fwd_be_t         fwd_be_rs2_dec,
    input  logic [rv_pkg::XLEN-1:0] ewbk_data,
    input  logic [rv_pkg::XLEN-1:0] wbk_data,
    output rv_pkg::rf_addr_t        ra1,
    output rv_pkg::rf_addr_t        ra2,
    output rv_pkg::rf_addr_t        rs1_dec,
    output rv_pkg::rf_addr_t        rs2_dec,
    output rv_pkg::alu_a_sel_t      alu_a_sel_dec,
    output rv_pkg::alu_b_sel_t      alu_b_sel_dec,
    output logic                    store_inst_dec,
    output rv_pkg::dec_exe_t        dec_exe
);

    logic [rv_pkg::XLEN-1:0] inst_q;
    logic                    inst_v_q;
    logic [6:0]              funct7;
    rv_pkg::dec_exe_t        dec_d;
    rv_pkg::dec_exe_t        dec_next;

    // fetched instruction, frozen while decode stalls
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_v_q <= 1'b0;
        end else if (!stall_dec) begin
            inst_v_q <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_dec) begin
            inst_q <= inst;
        end
    end

    assign funct7 = inst_q[31:25];

    always_comb begin
        dec_d = '0;
        if (inst_v_q) begin
            case (inst_q[6:0])
                rv_pkg::OPC_OP: begin
                    dec_d.valid = (funct7 == rv_pkg::F7_BASE);
                    dec_d.rd_we = 1'b1;
                    dec_d.rs1   = inst_q[19:15];
                    dec_d.rs2   = inst_q[24:20];
                    case (inst_q[14:12])
                        rv_pkg::F3_ADD_SUB: begin
                            dec_d.valid  = (funct7 == rv_pkg::F7_BASE) ||
                                           (funct7 == rv_pkg::F7_SUB);
                            dec_d.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                        end
                        rv_pkg::F3_XOR: dec_d.alu_op = rv_pkg::ALU_XOR;
                        rv_pkg::F3_OR:  dec_d.alu_op = rv_pkg::ALU_OR;
                        rv_pkg::F3_AND: dec_d.alu_op = rv_pkg::ALU_AND;
                        default:        dec_d.valid  = 1'b0;
                    endcase
                end
                rv_pkg::OPC_OP_IMM: begin
                    dec_d.valid     = (inst_q[14:12] == rv_pkg::F3_ADD_SUB);
                    dec_d.rd_we     = 1'b1;
                    dec_d.rs1       = inst_q[19:15];
                    dec_d.imm       = {{20{inst_q[31]}}, inst_q[31:20]};
                    dec_d.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                end
                rv_pkg::OPC_LUI: begin
                    dec_d.valid     = 1'b1;
                    dec_d.rd_we     = 1'b1;
                    dec_d.imm       = {inst_q[31:12], 12'b0};
                    dec_d.alu_op    = rv_pkg::ALU_PASS_B;
                    dec_d.alu_a_sel = rv_pkg::ALU_A_SEL_ZERO;
                    dec_d.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                end
                rv_pkg::OPC_LOAD: begin
                    dec_d.valid     = (inst_q[14:12] == rv_pkg::F3_WORD);
                    dec_d.rd_we     = 1'b1;
                    dec_d.load      = 1'b1;
                    dec_d.rs1       = inst_q[19:15];
                    dec_d.imm       = {{20{inst_q[31]}}, inst_q[31:20]};
                    dec_d.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                end
                rv_pkg::OPC_STORE: begin
                    dec_d.valid     = (inst_q[14:12] == rv_pkg::F3_WORD);
                    dec_d.store     = 1'b1;
                    dec_d.rs1       = inst_q[19:15];
                    dec_d.rs2       = inst_q[24:20];
                    dec_d.imm       = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
                    dec_d.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                end
                default: dec_d.valid = 1'b0;
            endcase
        end
        // unsupported encodings become bubbles, x0 destinations never write
        dec_d.rd_we = dec_d.rd_we && (inst_q[11:7] != rv_pkg::RF_X0_ZERO);
        dec_d.rd    = dec_d.rd_we ? inst_q[11:7] : rv_pkg::RF_X0_ZERO;
        if (!dec_d.valid) begin
            dec_d = '0;
        end
    end

    // register read with forwarding from memory or writeback
    always_comb begin
        dec_next = dec_d;
        if (rf_a_sel_fwd) begin
            dec_next.rs1_data = (fwd_be_rs1_dec == rv_pkg::FWD_BE_EWBK) ? ewbk_data : wbk_data;
        end else begin
            dec_next.rs1_data = rf_rd1;
        end
        if (rf_b_sel_fwd) begin
            dec_next.rs2_data = (fwd_be_rs2_dec == rv_pkg::FWD_BE_EWBK) ? ewbk_data : wbk_data;
        end else begin
            dec_next.rs2_data = rf_rd2;
        end
    end

    assign ra1            = dec_d.rs1;
    assign ra2            = dec_d.rs2;
    assign rs1_dec        = dec_d.rs1;
    assign rs2_dec        = dec_d.rs2;
    assign alu_a_sel_dec  = dec_d.alu_a_sel;
    assign alu_b_sel_dec  = dec_d.alu_b_sel;
    assign store_inst_dec = dec_d.store;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_exe <= '0;
        end else if (bubble_exe) begin
            dec_exe <= '0;
        end else if (!stall_dec) begin
            dec_exe <= dec_next;
        end
    end

endmodule

//--- rtl/rv_operand_forwarding.sv
`timescale 1ns/1ps

module rv_operand_forwarding (
    input  logic                 store_inst_dec,
    input  logic                 store_inst_exe,
    input  logic                 load_inst_mem,
    input  rv_pkg::rf_addr_t     rs1_dec,
    input  rv_pkg::rf_addr_t     rs2_dec,
    input  rv_pkg::rf_addr_t     rs1_exe,
    input  rv_pkg::rf_addr_t     rs2_exe,
    input  rv_pkg::rf_addr_t     rd_mem,
    input  rv_pkg::rf_addr_t     rd_wbk,
    input  logic                 rd_we_mem,
    input  logic                 rd_we_wbk,
    input  rv_pkg::alu_a_sel_t   alu_a_sel_dec,
    input  rv_pkg::alu_b_sel_t   alu_b_sel_dec,
    input  rv_pkg::alu_a_sel_t   alu_a_sel_exe,
    input  rv_pkg::alu_b_sel_t   alu_b_sel_exe,
    output rv_pkg::fwd_be_t      fwd_be_rs1_dec,
    output rv_pkg::fwd_be_t      fwd_be_rs2_dec,
    output rv_pkg::fwd_be_t      fwd_be_rs1_exe,
    output rv_pkg::fwd_be_t      fwd_be_rs2_exe,
    output rv_pkg::alu_a_sel_t   alu_a_sel_fwd,
    output rv_pkg::alu_b_sel_t   alu_b_sel_fwd,
    output logic                 st_data_sel_fwd,
    output logic                 rf_a_sel_fwd,
    output logic                 rf_b_sel_fwd,
    output rv_pkg::hazard_be_t   hazard_be
);

    logic rs1_dec_in_mem;
    logic rs2_dec_in_mem;
    logic rs1_exe_in_mem;
    logic rs2_exe_in_mem;
    logic rs1_dec_in_be;
    logic rs2_dec_in_be;
    logic rs1_exe_in_be;
    logic rs2_exe_in_be;

    function automatic logic hit_mem(input rv_pkg::rf_addr_t rs);
        hit_mem = (rs != rv_pkg::RF_X0_ZERO) && (rs == rd_mem) && rd_we_mem;
    endfunction

    function automatic logic hit_wbk(input rv_pkg::rf_addr_t rs);
        hit_wbk = (rs != rv_pkg::RF_X0_ZERO) && (rs == rd_wbk) && rd_we_wbk;
    endfunction

    assign rs1_dec_in_mem = hit_mem(rs1_dec);
    assign rs2_dec_in_mem = hit_mem(rs2_dec);
    assign rs1_exe_in_mem = hit_mem(rs1_exe);
    assign rs2_exe_in_mem = hit_mem(rs2_exe);

    assign rs1_dec_in_be = rs1_dec_in_mem || hit_wbk(rs1_dec);
    assign rs2_dec_in_be = rs2_dec_in_mem || hit_wbk(rs2_dec);
    assign rs1_exe_in_be = rs1_exe_in_mem || hit_wbk(rs1_exe);
    assign rs2_exe_in_be = rs2_exe_in_mem || hit_wbk(rs2_exe);

    // memory stage holds the younger result, so it wins over writeback
    assign fwd_be_rs1_dec = rs1_dec_in_mem ? rv_pkg::FWD_BE_EWBK : rv_pkg::FWD_BE_WBK;
    assign fwd_be_rs2_dec = rs2_dec_in_mem ? rv_pkg::FWD_BE_EWBK : rv_pkg::FWD_BE_WBK;
    assign fwd_be_rs1_exe = rs1_exe_in_mem ? rv_pkg::FWD_BE_EWBK : rv_pkg::FWD_BE_WBK;
    assign fwd_be_rs2_exe = rs2_exe_in_mem ? rv_pkg::FWD_BE_EWBK : rv_pkg::FWD_BE_WBK;

    // only a register operand gets redirected
    assign alu_a_sel_fwd = (rs1_exe_in_be && (alu_a_sel_exe == rv_pkg::ALU_A_SEL_RS1)) ?
        rv_pkg::ALU_A_SEL_FWD : alu_a_sel_exe;
    assign alu_b_sel_fwd = (rs2_exe_in_be && (alu_b_sel_exe == rv_pkg::ALU_B_SEL_RS2)) ?
        rv_pkg::ALU_B_SEL_FWD : alu_b_sel_exe;

    assign st_data_sel_fwd = rs2_exe_in_be && store_inst_exe;

    assign rf_a_sel_fwd = rs1_dec_in_be && (alu_a_sel_dec == rv_pkg::ALU_A_SEL_RS1);
    assign rf_b_sel_fwd = rs2_dec_in_be &&
        ((alu_b_sel_dec == rv_pkg::ALU_B_SEL_RS2) || store_inst_dec);

    // load data shows up only in writeback
    assign hazard_be.to_dec = load_inst_mem && (rs1_dec_in_mem || rs2_dec_in_mem);
    assign hazard_be.to_exe = load_inst_mem && (rs1_exe_in_mem || rs2_exe_in_mem);

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_pkg::dec_exe_t        dec_exe,
    input  rv_pkg::alu_a_sel_t      alu_a_sel_fwd,
    input  rv_pkg::alu_b_sel_t      alu_b_sel_fwd,
    input  logic                    st_data_sel_fwd,
    input  rv_pkg::fwd_be_t         fwd_be_rs1_exe,
    input  rv_pkg::fwd_be_t         fwd_be_rs2_exe,
    input  logic [rv_pkg::XLEN-1:0] ewbk_data,
    input  logic [rv_pkg::XLEN-1:0] wbk_data,
    input  logic                    hold_exe,
    input  logic                    bubble_mem,
    output rv_pkg::exe_mem_t        exe_mem
);

    logic [rv_pkg::XLEN-1:0] fwd_rs1;
    logic [rv_pkg::XLEN-1:0] fwd_rs2;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    rv_pkg::exe_mem_t        exe_next;

    assign fwd_rs1 = (fwd_be_rs1_exe == rv_pkg::FWD_BE_EWBK) ? ewbk_data : wbk_data;
    assign fwd_rs2 = (fwd_be_rs2_exe == rv_pkg::FWD_BE_EWBK) ? ewbk_data : wbk_data;

    always_comb begin
        case (alu_a_sel_fwd)
            rv_pkg::ALU_A_SEL_RS1: op_a = dec_exe.rs1_data;
            rv_pkg::ALU_A_SEL_FWD: op_a = fwd_rs1;
            default:               op_a = '0;
        endcase
        case (alu_b_sel_fwd)
            rv_pkg::ALU_B_SEL_RS2: op_b = dec_exe.rs2_data;
            rv_pkg::ALU_B_SEL_FWD: op_b = fwd_rs2;
            default:               op_b = dec_exe.imm;
        endcase
    end

    always_comb begin
        case (dec_exe.alu_op)
            rv_pkg::ALU_SUB: alu_res = op_a - op_b;
            rv_pkg::ALU_AND: alu_res = op_a & op_b;
            rv_pkg::ALU_OR:  alu_res = op_a | op_b;
            rv_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:         alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        exe_next.valid      = dec_exe.valid;
        exe_next.rd         = dec_exe.rd;
        exe_next.rd_we      = dec_exe.rd_we;
        exe_next.alu_res    = alu_res;
        // store data takes the same forwarding path as rs2
        exe_next.store_data = st_data_sel_fwd ? fwd_rs2 : dec_exe.rs2_data;
        exe_next.load       = dec_exe.load;
        exe_next.store      = dec_exe.store;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_mem <= '0;
        end else if (bubble_mem) begin
            exe_mem <= '0;
        end else if (!hold_exe) begin
            exe_mem <= exe_next;
        end
    end

endmodule

//--- rtl/rv_memory.sv
`timescale 1ns/1ps

module rv_memory (
    input  logic             clk,
    input  logic             arst_n,
    input  rv_pkg::exe_mem_t exe_mem,
    output rv_pkg::mem_wbk_t mem_wbk,
    output rv_pkg::wb_t      wb
);

    logic [rv_pkg::XLEN-1:0]        dmem [rv_pkg::DMEM_DEPTH];
    logic [rv_pkg::DMEM_ADDR_W-1:0] addr;
    logic [rv_pkg::XLEN-1:0]        load_data_q;

    // word address, low two bits ignored
    assign addr = exe_mem.alu_res[rv_pkg::DMEM_ADDR_W+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rv_pkg::DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (exe_mem.valid && exe_mem.store) begin
            dmem[addr] <= exe_mem.store_data;
        end
    end

    // synchronous read, data lands in writeback
    always_ff @(posedge clk) begin
        if (exe_mem.valid && exe_mem.load) begin
            load_data_q <= dmem[addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wbk <= '0;
        end else begin
            mem_wbk.valid   <= exe_mem.valid;
            mem_wbk.rd      <= exe_mem.rd;
            mem_wbk.rd_we   <= exe_mem.rd_we;
            mem_wbk.alu_res <= exe_mem.alu_res;
            mem_wbk.load    <= exe_mem.load;
        end
    end

    assign wb.valid = mem_wbk.valid && mem_wbk.rd_we;
    assign wb.rd    = mem_wbk.rd;
    assign wb.data  = mem_wbk.load ? load_data_q : mem_wbk.alu_res;

endmodule

//--- rtl/rv_pipe_top.sv
`timescale 1ns/1ps

module rv_pipe_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [rv_pkg::XLEN-1:0] inst,
    input  logic                    inst_valid,
    output logic                    stall,
    output rv_pkg::wb_t             wb
);

    rv_pkg::dec_exe_t        dec_exe;
    rv_pkg::exe_mem_t        exe_mem;
    rv_pkg::mem_wbk_t        mem_wbk;
    rv_pkg::hazard_be_t      hazard_be;
    rv_pkg::rf_addr_t        ra1;
    rv_pkg::rf_addr_t        ra2;
    rv_pkg::rf_addr_t        rs1_dec;
    rv_pkg::rf_addr_t        rs2_dec;
    rv_pkg::alu_a_sel_t      alu_a_sel_dec;
    rv_pkg::alu_b_sel_t      alu_b_sel_dec;
    rv_pkg::alu_a_sel_t      alu_a_sel_fwd;
    rv_pkg::alu_b_sel_t      alu_b_sel_fwd;
    rv_pkg::fwd_be_t         fwd_be_rs1_dec;
    rv_pkg::fwd_be_t         fwd_be_rs2_dec;
    rv_pkg::fwd_be_t         fwd_be_rs1_exe;
    rv_pkg::fwd_be_t         fwd_be_rs2_exe;
    logic [rv_pkg::XLEN-1:0] rf_rd1;
    logic [rv_pkg::XLEN-1:0] rf_rd2;
    logic                    store_inst_dec;
    logic                    st_data_sel_fwd;
    logic                    rf_a_sel_fwd;
    logic                    rf_b_sel_fwd;
    logic                    bubble_exe;

    // execute hazard wins: freeze both stages, bubble into memory
    assign stall      = hazard_be.to_dec || hazard_be.to_exe;
    assign bubble_exe = hazard_be.to_dec && !hazard_be.to_exe;

    rv_regfile rv_regfile_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (ra1),
        .ra2    (ra2),
        .wb     (wb),
        .rd1    (rf_rd1),
        .rd2    (rf_rd2)
    );

    rv_decode rv_decode_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .inst           (inst),
        .inst_valid     (inst_valid),
        .stall_dec      (stall),
        .bubble_exe     (bubble_exe),
        .rf_rd1         (rf_rd1),
        .rf_rd2         (rf_rd2),
        .rf_a_sel_fwd   (rf_a_sel_fwd),
        .rf_b_sel_fwd   (rf_b_sel_fwd),
        .fwd_be_rs1_dec (fwd_be_rs1_dec),
        .fwd_be_rs2_dec (fwd_be_rs2_dec),
        .ewbk_data      (exe_mem.alu_res),
        .wbk_data       (wb.data),
        .ra1            (ra1),
        .ra2            (ra2),
        .rs1_dec        (rs1_dec),
        .rs2_dec        (rs2_dec),
        .alu_a_sel_dec  (alu_a_sel_dec),
        .alu_b_sel_dec  (alu_b_sel_dec),
        .store_inst_dec (store_inst_dec),
        .dec_exe        (dec_exe)
    );

    rv_operand_forwarding rv_operand_forwarding_inst (
        .store_inst_dec  (store_inst_dec),
        .store_inst_exe  (dec_exe.store),
        .load_inst_mem   (exe_mem.load),
        .rs1_dec         (rs1_dec),
        .rs2_dec         (rs2_dec),
        .rs1_exe         (dec_exe.rs1),
        .rs2_exe         (dec_exe.rs2),
        .rd_mem          (exe_mem.rd),
        .rd_wbk          (mem_wbk.rd),
        .rd_we_mem       (exe_mem.rd_we),
        .rd_we_wbk       (mem_wbk.rd_we),
        .alu_a_sel_dec   (alu_a_sel_dec),
        .alu_b_sel_dec   (alu_b_sel_dec),
        .alu_a_sel_exe   (dec_exe.alu_a_sel),
        .alu_b_sel_exe   (dec_exe.alu_b_sel),
        .fwd_be_rs1_dec  (fwd_be_rs1_dec),
        .fwd_be_rs2_dec  (fwd_be_rs2_dec),
        .fwd_be_rs1_exe  (fwd_be_rs1_exe),
        .fwd_be_rs2_exe  (fwd_be_rs2_exe),
        .alu_a_sel_fwd   (alu_a_sel_fwd),
        .alu_b_sel_fwd   (alu_b_sel_fwd),
        .st_data_sel_fwd (st_data_sel_fwd),
        .rf_a_sel_fwd    (rf_a_sel_fwd),
        .rf_b_sel_fwd    (rf_b_sel_fwd),
        .hazard_be       (hazard_be)
    );

    rv_execute rv_execute_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .dec_exe         (dec_exe),
        .alu_a_sel_fwd   (alu_a_sel_fwd),
        .alu_b_sel_fwd   (alu_b_sel_fwd),
        .st_data_sel_fwd (st_data_sel_fwd),
        .fwd_be_rs1_exe  (fwd_be_rs1_exe),
        .fwd_be_rs2_exe  (fwd_be_rs2_exe),
        .ewbk_data       (exe_mem.alu_res),
        .wbk_data        (wb.data),
        .hold_exe        (hazard_be.to_exe),
        .bubble_mem      (hazard_be.to_exe),
        .exe_mem         (exe_mem)
    );

    rv_memory rv_memory_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .exe_mem (exe_mem),
        .mem_wbk (mem_wbk),
        .wb      (wb)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for three rising edges, released just after the third
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;
    end

endmodule

//--- sim/rv_pipe_assert.sv
`timescale 1ns/1ps

module rv_pipe_assert (
    input logic        clk,
    input logic        arst_n,
    input logic [31:0] inst,
    input logic        inst_valid,
    input logic        stall,
    input rv_pkg::wb_t wb
);

    logic [6:0] opc;
    logic       writes_reg;
    logic       accept_wr;

    assign opc = inst[6:0];

    // simple register writers, enough to time the pipeline latency
    assign writes_reg = (inst[11:7] != 5'd0) &&
        (((opc == rv_pkg::OPC_OP_IMM) && (inst[14:12] == 3'b000)) ||
         (opc == rv_pkg::OPC_LUI));

    assign accept_wr = inst_valid && !stall && writes_reg;

    no_unknown_outputs: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown({stall, wb})
    ) else $error("stall or wb carries an unknown value");

    no_x0_writeback: assert property (
        @(posedge clk) disable iff (!arst_n) wb.valid |-> (wb.rd != 5'd0)
    ) else $error("writeback strobe names x0");

    // accepted at edge N, seen on wb at edge N+4 when nothing stalls
    fixed_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        accept_wr ##1 !stall ##1 !stall ##1 !stall |=> wb.valid
    ) else $error("accepted instruction missed its 4 cycle writeback");

endmodule

bind rv_pipe_top rv_pipe_assert rv_pipe_assert_inst (.*);

//--- sim/rv_pipe_tb.sv
`timescale 1ns/1ps

module rv_pipe_tb;

    localparam int N_DIRECTED   = 31;
    localparam int N_RANDOM     = 300;
    localparam int MAX_CYCLES   = 6 * (N_DIRECTED + N_RANDOM) + 20;
    localparam int DRAIN_CYCLES = 10;

    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_ADDI = 5;
    localparam int K_LUI  = 6;
    localparam int K_LW   = 7;
    localparam int K_SW   = 8;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst;
    logic        inst_valid;
    logic        stall;
    rv_pkg::wb_t wb;

    // reference machine state
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [256];
    rv_pkg::wb_t expect_q [$];
    string       test_name;
    int          cycles;
    logic        saw_stall;

    tb_clock_gen tb_clock_gen_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_pipe_top rv_pipe_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .stall      (stall),
        .wb         (wb)
    );

    task automatic fail_run(input string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("*** FAILED ***");
        $fatal(1, "run stopped on error");
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_r = {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    // present one word and wait until the pipeline takes it
    task automatic drive_inst(input logic [31:0] word);
        logic taken;
        inst       = word;
        inst_valid = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !stall;
            @(posedge clk);
        end
        #2;
        inst_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // run one instruction on the model and then send it to the DUT
    task automatic exec(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] simm;
        logic [31:0] word;
        logic        writes;
        rv_pkg::wb_t e;
        a      = model_regs[rs1];
        b      = model_regs[rs2];
        simm   = {{20{imm[11]}}, imm[11:0]};
        addr   = a + simm;
        writes = 1'b1;
        res    = '0;
        word   = '0;
        case (kind)
            K_ADD: begin
                res  = a + b;
                word = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
            end
            K_SUB: begin
                res  = a - b;
                word = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
            end
            K_AND: begin
                res  = a & b;
                word = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
            end
            K_OR: begin
                res  = a | b;
                word = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
            end
            K_XOR: begin
                res  = a ^ b;
                word = enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
            end
            K_ADDI: begin
                res  = a + simm;
                word = enc_i(imm[11:0], rs1, 3'b000, rd, rv_pkg::OPC_OP_IMM);
            end
            K_LUI: begin
                res  = {imm[31:12], 12'b0};
                word = {imm[31:12], rd, rv_pkg::OPC_LUI};
            end
            K_LW: begin
                res  = model_mem[addr[9:2]];
                word = enc_i(imm[11:0], rs1, 3'b010, rd, rv_pkg::OPC_LOAD);
            end
            default: begin
                model_mem[addr[9:2]] = b;
                writes = 1'b0;
                word   = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
            end
        endcase
        if (writes && (rd != 5'd0)) begin
            model_regs[rd] = res;
            e.valid = 1'b1;
            e.rd    = rd;
            e.data  = res;
            expect_q.push_back(e);
        end
        drive_inst(word);
    endtask

    // compare every writeback with the oldest expected result
    always @(negedge clk) begin
        rv_pkg::wb_t head;
        if (arst_n && wb.valid) begin
            writeback_expected: assert (expect_q.size() != 0) else begin
                fail_run("writeback seen while no register write was expected");
            end
            head = expect_q.pop_front();
            wb_matches_model: assert (wb == head) else begin
                $display("[ERROR] %s: expected rd=x%0d data=%08h, actual rd=x%0d data=%08h",
                         test_name, head.rd, head.data, wb.rd, wb.data);
                fail_run("");
            end
        end
    end

    always @(negedge clk) begin
        if (stall) begin
            saw_stall = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            fail_run("timeout, the pipeline did not finish within the cycle limit");
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] k;
        int          waited;
        inst       = '0;
        inst_valid = 1'b0;
        cycles     = 0;
        saw_stall  = 1'b0;
        test_name  = "reset";
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = '0;
        end
        void'($urandom(50));
        @(posedge arst_n);
        @(posedge clk);
        #2;

        test_name = "independent_alu";
        exec(K_LUI, 5'd1, 5'd0, 5'd0, 32'h12345000);
        exec(K_ADDI, 5'd5, 5'd0, 5'd0, 32'h00000055);
        exec(K_ADDI, 5'd6, 5'd0, 5'd0, 32'hFFFFFFF9);
        exec(K_ADDI, 5'd7, 5'd0, 5'd0, 32'h0000003C);
        idle(4);
        exec(K_AND, 5'd8, 5'd5, 5'd7, 32'h0);
        exec(K_OR, 5'd9, 5'd1, 5'd6, 32'h0);
        exec(K_XOR, 5'd10, 5'd5, 5'd6, 32'h0);
        exec(K_SUB, 5'd11, 5'd7, 5'd5, 32'h0);
        idle(6);

        // x1 written at distance 1, 2 and 3 while both stages hold x1
        test_name = "forward_distance";
        exec(K_ADDI, 5'd1, 5'd0, 5'd0, 32'd10);
        exec(K_ADDI, 5'd1, 5'd1, 5'd0, 32'd5);
        exec(K_ADD, 5'd2, 5'd1, 5'd1, 32'h0);
        exec(K_XOR, 5'd3, 5'd1, 5'd2, 32'h0);
        exec(K_SUB, 5'd4, 5'd2, 5'd1, 32'h0);
        exec(K_OR, 5'd5, 5'd4, 5'd3, 32'h0);
        idle(6);

        test_name = "load_use";
        exec(K_ADDI, 5'd1, 5'd0, 5'd0, 32'h00000040);
        exec(K_ADDI, 5'd2, 5'd0, 5'd0, 32'd77);
        exec(K_SW, 5'd0, 5'd1, 5'd2, 32'h0);
        idle(4);
        saw_stall = 1'b0;
        exec(K_LW, 5'd3, 5'd1, 5'd0, 32'h0);
        exec(K_ADD, 5'd4, 5'd3, 5'd3, 32'h0);
        idle(6);
        load_use_stalls: assert (saw_stall) else begin
            fail_run("a load followed by a dependent use did not raise stall");
        end
        exec(K_LW, 5'd5, 5'd1, 5'd0, 32'h0);
        exec(K_ADDI, 5'd6, 5'd0, 5'd0, 32'd1);
        exec(K_ADD, 5'd7, 5'd5, 5'd6, 32'h0);
        idle(6);

        test_name = "store_forward";
        exec(K_ADDI, 5'd2, 5'd0, 5'd0, 32'h00000123);
        exec(K_SW, 5'd0, 5'd1, 5'd2, 32'h00000008);
        exec(K_LW, 5'd3, 5'd1, 5'd0, 32'h00000008);
        exec(K_ADD, 5'd4, 5'd3, 5'd2, 32'h0);
        idle(6);

        test_name = "x0_handling";
        exec(K_ADDI, 5'd0, 5'd0, 5'd0, 32'd55);
        exec(K_ADD, 5'd1, 5'd0, 5'd0, 32'h0);
        exec(K_LUI, 5'd0, 5'd0, 5'd0, 32'hABCDE000);
        exec(K_ADDI, 5'd2, 5'd0, 5'd0, 32'd9);
        exec(K_OR, 5'd3, 5'd0, 5'd2, 32'h0);
        idle(6);

        // registers limited to x0..x3 so dependences are dense
        test_name = "random_stream";
        for (int i = 0; i < N_RANDOM; i++) begin
            k = $urandom % 9;
            r = $urandom;
            exec(int'(k), {3'b0, r[1:0]}, {3'b0, r[3:2]}, {3'b0, r[5:4]}, $urandom);
        end

        test_name = "drain";
        waited    = 0;
        while ((expect_q.size() != 0) && (waited < DRAIN_CYCLES)) begin
            @(posedge clk);
            waited++;
        end
        idle(6);
        if (expect_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("expected writebacks were still outstanding at the end");
        end
    end

endmodule

//--- project.f
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_operand_forwarding.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_pipe_top.sv
sim/tb_clock_gen.sv
sim/rv_pipe_assert.sv
sim/rv_pipe_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_pipe_tb -f project.f -o rv_pipe_sim

./obj_dir/rv_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation ok"
